// File: project.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/op_decode.sv
rtl/timing_fsm.sv
rtl/addr_unit.sv
rtl/alu_regs.sv
rtl/cpu_core.sv
testbench/cpu_props.sv
testbench/cpu_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module cpu_tb -Mdir obj_dir
	./obj_dir/Vcpu_tb | tee $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: testbench/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_tb;

    // instructions over all tests, rounded up
    localparam int N_INSNS = 140;
    // margin covers the resets and the jam hold
    localparam int WATCHDOG_CYCLES = N_INSNS * 3 + 300;
    localparam int RUN_LIMIT = 100;

    logic               clk_m1;
    logic               rst;
    logic [`CPU_DW-1:0] data_i;
    logic [`CPU_AW-1:0] addr_o;
    logic [`CPU_DW-1:0] data_o;
    logic               rw_o;
    logic               sync_o;
    logic               jam_o;

    logic [7:0]  mem [0:65535];
    logic [15:0] pc_w;
    logic [15:0] halt_addr;
    logic [15:0] sync_q [$];
    int          gap_q [$];
    int          n_checks;
    int          n_errors;
    logic        bus_fault;

    cpu_core dut_i (
        .clk_m1 (clk_m1),
        .rst    (rst),
        .data_i (data_i),
        .addr_o (addr_o),
        .data_o (data_o),
        .rw_o   (rw_o),
        .sync_o (sync_o),
        .jam_o  (jam_o)
    );

    bind cpu_core cpu_props props_i (
        .clk_m1 (clk_m1),
        .rst    (rst),
        .addr_i (addr_o),
        .rw_i   (rw_o),
        .sync_i (sync_o),
        .jam_i  (jam_o)
    );

    initial begin
        clk_m1 = 1'b0;
        forever begin
            #5 clk_m1 = ~clk_m1;
        end
    end

    // memory answers within the cycle, stores land mid-cycle
    always @(negedge clk_m1) begin
        if (!rst && !rw_o) begin
            mem[addr_o] = data_o;
        end
        data_i = mem[addr_o];
    end

    // bus rules again, a fault ends the run
    always @(negedge clk_m1) begin
        if (!rst) begin
            if ((sync_o && !rw_o) || (jam_o && sync_o) || (!rw_o && addr_o[15:8] != 8'h00)) begin
                bus_fault = 1'b1;
            end
        end
    end

    // background fill, depends on every address bit
    function automatic logic [7:0] fill_byte(input logic [15:0] a);
        return a[15:8] ^ {a[4:0], a[7:5]} ^ 8'h5A;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $urandom();
        return r[7:0];
    endfunction

    // op index 0..3 is adc, and, ora, eor
    function automatic logic [7:0] alu_opcode(input int op, input logic zp);
        case (op)
            0: return zp ? `OPC_ADC_ZP : `OPC_ADC_IMM;
            1: return zp ? `OPC_AND_ZP : `OPC_AND_IMM;
            2: return zp ? `OPC_ORA_ZP : `OPC_ORA_IMM;
            default: return zp ? `OPC_EOR_ZP : `OPC_EOR_IMM;
        endcase
    endfunction

    // reference ALU, {carry, result}, carry kept by logic ops
    function automatic logic [8:0] alu_expect(input int op, input logic [7:0] a,
                                              input logic [7:0] b, input logic c);
        logic [8:0] r;
        case (op)
            0: r = {1'b0, a} + {1'b0, b} + {8'h00, c};
            1: r = {c, a & b};
            2: r = {c, a | b};
            default: r = {c, a ^ b};
        endcase
        return r;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error %s: got %0h, expected %0h", name, got, exp);
        end
    endtask

    task automatic emit(input logic [7:0] b);
        mem[pc_w] = b;
        pc_w = pc_w + 16'd1;
    endtask

    task automatic emit2(input logic [7:0] op, input logic [7:0] operand);
        emit(op);
        emit(operand);
    endtask

    // JMP to itself marks the end of a program
    task automatic emit_halt();
        halt_addr = pc_w;
        emit(`OPC_JMP_ABS);
        emit2(halt_addr[7:0], halt_addr[15:8]);
    endtask

    // core held in reset while memory is rebuilt
    task automatic new_prog();
        int a;
        @(negedge clk_m1);
        rst = 1'b1;
        for (a = 0; a < 65536; a++) begin
            mem[a] = fill_byte(a[15:0]);
        end
        pc_w = `CPU_RESET_ADDR;
    endtask

    task automatic start_prog();
        repeat (2) @(negedge clk_m1);
        rst = 1'b0;
    endtask

    // records every fetch address and the cycles since the previous one
    task automatic run_to_halt();
        int   cyc;
        int   last;
        logic done;
        cyc = 0;
        last = 0;
        done = 1'b0;
        sync_q.delete();
        gap_q.delete();
        while (!done && cyc < RUN_LIMIT) begin
            if (sync_o) begin
                sync_q.push_back(addr_o);
                gap_q.push_back(cyc - last);
                last = cyc;
                done = (addr_o == halt_addr);
            end
            if (!done) begin
                @(negedge clk_m1);
                cyc++;
            end
        end
        if (!done) begin
            n_errors++;
            $display("program never reached its halt loop at %h", halt_addr);
        end
    endtask

    task automatic test_reset_fetch();
        new_prog();
        emit(`OPC_NOP);
        emit_halt();
        start_prog();
        // first cycle out of reset fetches from the reset address
        check_eq("sync_o", sync_o, 1);
        check_eq("addr_o", addr_o, `CPU_RESET_ADDR);
        check_eq("rw_o", rw_o, 1);
        check_eq("jam_o", jam_o, 0);
        run_to_halt();
        check_eq("sync count", sync_q.size(), 2);
        if (sync_q.size() == 2) begin
            check_eq("addr_o after nop", sync_q[1], `CPU_RESET_ADDR + 1);
            check_eq("nop length", gap_q[1], 2);
        end
    endtask

    task automatic test_load_store();
        logic [7:0] va;
        logic [7:0] vx;
        logic [7:0] vy;
        int         exp_gap [7] = '{0, 2, 3, 2, 3, 3, 3};
        int         i;
        va = rand_byte();
        vx = rand_byte();
        vy = rand_byte();
        new_prog();
        mem[16'h0040] = vx;
        emit2(`OPC_LDA_IMM, va);
        emit2(`OPC_LDX_ZP, 8'h40);
        emit2(`OPC_LDY_IMM, vy);
        emit2(`OPC_STA_ZP, 8'h10);
        emit2(`OPC_STX_ZP, 8'h11);
        emit2(`OPC_STY_ZP, 8'h12);
        emit_halt();
        start_prog();
        run_to_halt();
        check_eq("mem[0010]", mem[16'h0010], va);
        check_eq("mem[0011]", mem[16'h0011], vx);
        check_eq("mem[0012]", mem[16'h0012], vy);
        check_eq("sync count", gap_q.size(), 7);
        for (i = 0; i < gap_q.size() && i < 7; i++) begin
            check_eq($sformatf("sync gap %0d", i), gap_q[i], exp_gap[i]);
        end
    endtask

    task automatic test_alu();
        string      op_name [4] = '{"adc", "and", "ora", "eor"};
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] d;
        logic [8:0] r1;
        logic [8:0] r2;
        logic       c;
        int         op;
        int         zp;
        int         k;
        for (op = 0; op < 4; op++) begin
            for (zp = 0; zp < 2; zp++) begin
                for (k = 0; k < 2; k++) begin
                    a = rand_byte();
                    b = rand_byte();
                    c = k[0];
                    r1 = alu_expect(op, a, b, c);
                    new_prog();
                    mem[16'h0020] = b;
                    emit2(`OPC_LDA_IMM, a);
                    emit(c ? `OPC_SEC : `OPC_CLC);
                    emit2(alu_opcode(op, zp[0]), zp[0] ? 8'h20 : b);
                    emit2(`OPC_STA_ZP, 8'h30);
                    emit_halt();
                    start_prog();
                    run_to_halt();
                    check_eq($sformatf("%s mem[0030]", op_name[op]), mem[16'h0030], r1[7:0]);
                end
            end
        end
        // carry of the first ADC feeds the second
        for (k = 0; k < 3; k++) begin
            a = rand_byte();
            b = rand_byte();
            d = rand_byte();
            c = k[0];
            if (k == 0) begin
                // both top bits set, carry out is certain
                a = a | 8'h80;
                b = b | 8'h80;
            end
            r1 = alu_expect(0, a, b, c);
            r2 = alu_expect(0, r1[7:0], d, r1[8]);
            new_prog();
            mem[16'h0021] = d;
            emit(c ? `OPC_SEC : `OPC_CLC);
            emit2(`OPC_LDA_IMM, a);
            emit2(`OPC_ADC_IMM, b);
            emit2(`OPC_ADC_ZP, 8'h21);
            emit2(`OPC_STA_ZP, 8'h31);
            emit_halt();
            start_prog();
            run_to_halt();
            check_eq("adc chain mem[0031]", mem[16'h0031], r2[7:0]);
        end
    endtask

    task automatic test_transfer_wrap();
        logic [7:0] v;
        v = rand_byte();
        new_prog();
        emit2(`OPC_LDX_IMM, 8'hFF);
        emit(`OPC_INX);
        emit(`OPC_TXA);
        emit2(`OPC_STA_ZP, 8'h50);
        emit2(`OPC_LDY_IMM, 8'h00);
        emit(`OPC_DEY);
        emit2(`OPC_STY_ZP, 8'h51);
        emit2(`OPC_LDA_IMM, v);
        emit(`OPC_TAY);
        emit2(`OPC_LDA_IMM, 8'h00);
        emit(`OPC_TYA);
        emit2(`OPC_STA_ZP, 8'h52);
        emit(`OPC_TAX);
        emit(`OPC_DEX);
        emit2(`OPC_STX_ZP, 8'h53);
        emit(`OPC_INY);
        emit2(`OPC_STY_ZP, 8'h54);
        emit_halt();
        start_prog();
        run_to_halt();
        check_eq("mem[0050]", mem[16'h0050], 8'h00);
        check_eq("mem[0051]", mem[16'h0051], 8'hFF);
        check_eq("mem[0052]", mem[16'h0052], v);
        // byte-wide wrap, not the 32-bit sum
        check_eq("mem[0053]", mem[16'h0053], 8'(v - 8'd1));
        check_eq("mem[0054]", mem[16'h0054], 8'(v + 8'd1));
    endtask

    task automatic test_jmp();
        logic [15:0] target;
        logic [7:0]  v;
        target = 16'h0345;
        v = rand_byte();
        // stored value must differ from the background fill
        if (v == fill_byte(16'h0060)) begin
            v = ~v;
        end
        new_prog();
        emit2(`OPC_LDA_IMM, v);
        emit(`OPC_JMP_ABS);
        emit2(target[7:0], target[15:8]);
        // skipped by the jump
        emit2(`OPC_STA_ZP, 8'h60);
        pc_w = target;
        emit2(`OPC_STA_ZP, 8'h61);
        emit_halt();
        start_prog();
        run_to_halt();
        check_eq("sync count", sync_q.size(), 4);
        if (sync_q.size() >= 3) begin
            check_eq("addr_o after jmp", sync_q[2], target);
            check_eq("jmp length", gap_q[2], 3);
        end
        check_eq("mem[0060]", mem[16'h0060], fill_byte(16'h0060));
        check_eq("mem[0061]", mem[16'h0061], v);
    endtask

    task automatic test_jam();
        int cyc;
        int k;
        new_prog();
        emit2(`OPC_LDA_IMM, rand_byte());
        // 02 has no meaning in the kept set
        emit(8'h02);
        start_prog();
        cyc = 0;
        while (!jam_o && cyc < RUN_LIMIT) begin
            @(negedge clk_m1);
            cyc++;
        end
        if (!jam_o) begin
            n_errors++;
            $display("jam_o never rose after opcode 02");
        end
        for (k = 0; k < 20; k++) begin
            @(negedge clk_m1);
            check_eq("sync_o", sync_o, 0);
            check_eq("rw_o", rw_o, 1);
            check_eq("jam_o", jam_o, 1);
        end
    endtask

    task automatic close_run();
        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    // watchdog and bus fault, whichever comes first
    initial begin
        fork
            begin
                #(WATCHDOG_CYCLES * 10);
                $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
            end
            begin
                wait (bus_fault);
                $display("bus protocol broken at %0t, run stopped", $time);
            end
        join_any
        n_errors++;
        close_run();
    end

    initial begin
        rst = 1'b1;
        data_i = '0;
        bus_fault = 1'b0;
        n_checks = 0;
        n_errors = 0;
        pc_w = `CPU_RESET_ADDR;
        halt_addr = `CPU_RESET_ADDR;
        void'($urandom(32'h26ab));
        test_reset_fetch();
        test_load_store();
        test_alu();
        test_transfer_wrap();
        test_jmp();
        test_jam();
        close_run();
    end

endmodule

// File: testbench/cpu_props.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

// bus rules, sampled on every rising edge outside reset
module cpu_props (
    input logic               clk_m1,
    input logic               rst,
    input logic [`CPU_AW-1:0] addr_i,
    input logic               rw_i,
    input logic               sync_i,
    input logic               jam_i
);

    // an opcode fetch is always a read
    fetch_is_read: assert property (
        @(posedge clk_m1) disable iff (rst) sync_i |-> rw_i
    ) else $error("write cycle during opcode fetch at %h", addr_i);

    // jammed core starts no instruction
    jam_no_sync: assert property (
        @(posedge clk_m1) disable iff (rst) jam_i |-> !sync_i
    ) else $error("sync_o high while jam_o is high");

    // stores exist only in zero-page mode
    write_in_zp: assert property (
        @(posedge clk_m1) disable iff (rst) !rw_i |-> (addr_i[15:8] == `CPU_ZP_PAGE)
    ) else $error("write cycle outside zero page at %h", addr_i);

endmodule

// File: rtl/cpu_core.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_core import cpu_pkg::*; (
    input  logic               clk_m1,
    input  logic               rst,
    input  logic [`CPU_DW-1:0] data_i,
    output logic [`CPU_AW-1:0] addr_o,
    output logic [`CPU_DW-1:0] data_o,
    output logic               rw_o,
    output logic               sync_o,
    output logic               jam_o
);

    dec_t     dec;
    bus_ctl_t ctl;
    exec_t    ex;

    // opcode captured while sync_o marks the fetch
    op_decode u_decode (
        .clk_m1  (clk_m1),
        .rst     (rst),
        .fetch_i (sync_o),
        .data_i  (data_i),
        .dec_o   (dec)
    );

    timing_fsm u_fsm (
        .clk_m1 (clk_m1),
        .rst    (rst),
        .dec_i  (dec),
        .ctl_o  (ctl),
        .ex_o   (ex),
        .sync_o (sync_o),
        .rw_o   (rw_o),
        .jam_o  (jam_o)
    );

    addr_unit u_addr (
        .clk_m1 (clk_m1),
        .rst    (rst),
        .ctl_i  (ctl),
        .data_i (data_i),
        .addr_o (addr_o)
    );

    // data_o loads on the edge before the write cycle
    alu_regs u_alu (
        .clk_m1  (clk_m1),
        .rst     (rst),
        .dec_i   (dec),
        .ex_i    (ex),
        .write_i (ctl.write),
        .data_i  (data_i),
        .data_o  (data_o)
    );

endmodule

// File: rtl/alu_regs.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module alu_regs import cpu_pkg::*; (
    input  logic               clk_m1,
    input  logic               rst,
    input  dec_t               dec_i,
    input  exec_t              ex_i,
    input  logic               write_i,
    input  logic [`CPU_DW-1:0] data_i,
    output logic [`CPU_DW-1:0] data_o
);

    logic [`CPU_DW-1:0] a_q;
    logic [`CPU_DW-1:0] x_q;
    logic [`CPU_DW-1:0] y_q;
    logic               c_q;
    logic [`CPU_DW-1:0] src_val;
    logic [`CPU_DW-1:0] opnd;
    logic [`CPU_DW-1:0] res;
    logic [`CPU_DW:0]   sum;

    // source register, zero when none
    always_comb begin
        case (dec_i.src)
            R_A:     src_val = a_q;
            R_X:     src_val = x_q;
            R_Y:     src_val = y_q;
            default: src_val = '0;
        endcase
    end

    // memory operand or a register transfer
    assign opnd = ex_i.from_mem ? data_i : src_val;

    // carry out lands in the top bit
    assign sum = {1'b0, src_val} + {1'b0, opnd} + {{`CPU_DW{1'b0}}, c_q};

    always_comb begin
        case (dec_i.alu_op)
            ALU_ADC: res = sum[`CPU_DW-1:0];
            ALU_AND: res = src_val & opnd;
            ALU_ORA: res = src_val | opnd;
            ALU_EOR: res = src_val ^ opnd;
            // inc/dec wrap at the byte boundary
            ALU_INC: res = src_val + 1'b1;
            ALU_DEC: res = src_val - 1'b1;
            default: res = opnd;
        endcase
    end

    // register file, written on the last cycle only
    always_ff @(posedge clk_m1) begin
        if (rst) begin
            a_q <= '0;
            x_q <= '0;
            y_q <= '0;
            c_q <= 1'b0;
        end else if (ex_i.exec) begin
            case (dec_i.dst)
                R_A:     a_q <= res;
                R_X:     x_q <= res;
                R_Y:     y_q <= res;
                default: ;
            endcase
            if (dec_i.carry_set) begin
                c_q <= 1'b1;
            end else if (dec_i.carry_clr) begin
                c_q <= 1'b0;
            end else if (dec_i.alu_op == ALU_ADC) begin
                c_q <= sum[`CPU_DW];
            end
        end
    end

    // store data, valid for the whole write cycle
    always_ff @(posedge clk_m1) begin
        if (write_i) begin
            data_o <= src_val;
        end
    end

endmodule

// File: rtl/addr_unit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module addr_unit import cpu_pkg::*; (
    input  logic                clk_m1,
    input  logic                rst,
    input  bus_ctl_t            ctl_i,
    input  logic [`CPU_DW-1:0]  data_i,
    output logic [`CPU_AW-1:0]  addr_o
);

    logic [`CPU_AW-1:0] pc_q;
    logic [`CPU_AW-1:0] pc_nx;
    logic [`CPU_AW-1:0] target;
    logic [`CPU_DW-1:0] lo_q;

    // jump target, high byte straight off the bus
    assign target = {data_i, lo_q};

    always_comb begin
        pc_nx = pc_q;
        if (ctl_i.pc_inc) begin
            pc_nx = pc_q + 1'b1;
        end
        if (ctl_i.pc_jump) begin
            pc_nx = target;
        end
    end

    // pc and address register
    always_ff @(posedge clk_m1) begin
        if (rst) begin
            pc_q   <= `CPU_RESET_ADDR;
            addr_o <= `CPU_RESET_ADDR;
        end else begin
            pc_q <= pc_nx;
            // zero-page cycle leaves pc parked past the operand
            if (ctl_i.addr_zp) begin
                addr_o <= {`CPU_ZP_PAGE, data_i};
            end else begin
                addr_o <= pc_nx;
            end
        end
    end

    // operand low byte for JMP
    always_ff @(posedge clk_m1) begin
        if (ctl_i.lo_latch) begin
            lo_q <= data_i;
        end
    end

endmodule

// File: rtl/timing_fsm.sv
`timescale 1ns/1ps

module timing_fsm import cpu_pkg::*; (
    input  logic     clk_m1,
    input  logic     rst,
    input  dec_t     dec_i,
    output bus_ctl_t ctl_o,
    output exec_t    ex_o,
    output logic     sync_o,
    output logic     rw_o,
    output logic     jam_o
);

    t_state_e state_q;
    t_state_e state_nx;

    // controls here act on the edge that ends the current cycle
    always_comb begin
        state_nx = state_q;
        ctl_o    = '0;
        ex_o     = '0;
        case (state_q)
            T1: begin
                // opcode on the bus, next read is the byte after it
                ctl_o.pc_inc = 1'b1;
                state_nx     = T2;
            end
            T2: begin
                // opcode now held, dec_i is valid from here on
                case (dec_i.op_class)
                    CL_IMM: begin
                        ctl_o.pc_inc  = 1'b1;
                        ctl_o.sync    = 1'b1;
                        ex_o.exec     = 1'b1;
                        ex_o.from_mem = 1'b1;
                        state_nx      = T1;
                    end
                    CL_IMPL: begin
                        // dummy read done, refetch the same address
                        ctl_o.sync = 1'b1;
                        ex_o.exec  = 1'b1;
                        state_nx   = T1;
                    end
                    CL_ZPG_RD, CL_ZPG_WR: begin
                        ctl_o.pc_inc  = 1'b1;
                        ctl_o.addr_zp = 1'b1;
                        ctl_o.write   = (dec_i.op_class == CL_ZPG_WR);
                        state_nx      = T3;
                    end
                    CL_JMP: begin
                        // low byte of target into the latch
                        ctl_o.pc_inc   = 1'b1;
                        ctl_o.lo_latch = 1'b1;
                        state_nx       = T3;
                    end
                    default: state_nx = T_JAM;
                endcase
            end
            T3: begin
                case (dec_i.op_class)
                    CL_ZPG_RD, CL_ZPG_WR, CL_JMP: begin
                        ctl_o.sync    = 1'b1;
                        ctl_o.pc_jump = (dec_i.op_class == CL_JMP);
                        ex_o.exec     = 1'b1;
                        ex_o.from_mem = (dec_i.op_class == CL_ZPG_RD);
                        state_nx      = T1;
                    end
                    default: state_nx = T_JAM;
                endcase
            end
            // T_JAM holds until reset
            default: state_nx = T_JAM;
        endcase
    end

    // bus status registered for the cycle it describes
    always_ff @(posedge clk_m1) begin
        if (rst) begin
            state_q <= T1;
            sync_o  <= 1'b1;
            rw_o    <= 1'b1;
            jam_o   <= 1'b0;
        end else begin
            state_q <= state_nx;
            sync_o  <= ctl_o.sync;
            rw_o    <= ~ctl_o.write;
            jam_o   <= (state_nx == T_JAM);
        end
    end

endmodule

// File: rtl/op_decode.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module op_decode import cpu_pkg::*; (
    input  logic    clk_m1,
    input  logic    rst,
    input  logic    fetch_i,
    input  opcode_u data_i,
    output dec_t    dec_o
);

    opcode_u  ir;
    logic     mode_zp;
    logic     mode_imm;
    reg_sel_e grp_reg;
    op_class_e ld_class;

    // opcode held from the edge that ends T1
    always_ff @(posedge clk_m1) begin
        if (rst) begin
            ir.raw <= `OPC_NOP;
        end else if (fetch_i) begin
            ir <= data_i;
        end
    end

    // zero page is bbb=001 in every group
    assign mode_zp  = (ir.f.bbb == 3'b001);
    // immediate sits at bbb=010 in group one, bbb=000 elsewhere
    assign mode_imm = (ir.f.cc == 2'b01) ? (ir.f.bbb == 3'b010) : (ir.f.bbb == 3'b000);
    assign ld_class = mode_imm ? CL_IMM : (mode_zp ? CL_ZPG_RD : CL_BAD);

    // cc picks the register for loads and stores
    always_comb begin
        case (ir.f.cc)
            2'b01:   grp_reg = R_A;
            2'b10:   grp_reg = R_X;
            2'b00:   grp_reg = R_Y;
            default: grp_reg = R_NONE;
        endcase
    end

    always_comb begin
        dec_o = '{op_class: CL_BAD, alu_op: ALU_PASS, src: R_NONE, dst: R_NONE,
                  carry_set: 1'b0, carry_clr: 1'b0};
        // single-byte ops and JMP match on the whole byte
        case (ir.raw)
            `OPC_INX: dec_o = '{CL_IMPL, ALU_INC, R_X, R_X, 1'b0, 1'b0};
            `OPC_INY: dec_o = '{CL_IMPL, ALU_INC, R_Y, R_Y, 1'b0, 1'b0};
            `OPC_DEX: dec_o = '{CL_IMPL, ALU_DEC, R_X, R_X, 1'b0, 1'b0};
            `OPC_DEY: dec_o = '{CL_IMPL, ALU_DEC, R_Y, R_Y, 1'b0, 1'b0};
            `OPC_TAX: dec_o = '{CL_IMPL, ALU_PASS, R_A, R_X, 1'b0, 1'b0};
            `OPC_TAY: dec_o = '{CL_IMPL, ALU_PASS, R_A, R_Y, 1'b0, 1'b0};
            `OPC_TXA: dec_o = '{CL_IMPL, ALU_PASS, R_X, R_A, 1'b0, 1'b0};
            `OPC_TYA: dec_o = '{CL_IMPL, ALU_PASS, R_Y, R_A, 1'b0, 1'b0};
            `OPC_CLC: dec_o = '{CL_IMPL, ALU_PASS, R_NONE, R_NONE, 1'b0, 1'b1};
            `OPC_SEC: dec_o = '{CL_IMPL, ALU_PASS, R_NONE, R_NONE, 1'b1, 1'b0};
            `OPC_NOP: dec_o = '{CL_IMPL, ALU_PASS, R_NONE, R_NONE, 1'b0, 1'b0};
            `OPC_JMP_ABS: dec_o = '{CL_JMP, ALU_PASS, R_NONE, R_NONE, 1'b0, 1'b0};
            default: begin
                if (ir.f.cc != 2'b11 && ir.f.aaa == 3'b101) begin
                    // LDA/LDX/LDY
                    dec_o.op_class = ld_class;
                    dec_o.dst      = grp_reg;
                end else if (ir.f.cc != 2'b11 && ir.f.aaa == 3'b100) begin
                    // STA/STX/STY, zero page only
                    dec_o.op_class = mode_zp ? CL_ZPG_WR : CL_BAD;
                    dec_o.src      = grp_reg;
                end else if (ir.f.cc == 2'b01 && !ir.f.aaa[2]) begin
                    // group one ALU ops on A
                    dec_o.op_class = ld_class;
                    dec_o.src      = R_A;
                    dec_o.dst      = R_A;
                    case (ir.f.aaa[1:0])
                        2'b00:   dec_o.alu_op = ALU_ORA;
                        2'b01:   dec_o.alu_op = ALU_AND;
                        2'b10:   dec_o.alu_op = ALU_EOR;
                        default: dec_o.alu_op = ALU_ADC;
                    endcase
                end
            end
        endcase
    end

endmodule

// File: rtl/cpu_pkg.sv
`include "cpu_macros.svh"

package cpu_pkg;

    // 6502 opcode fields, aaa selects the op, bbb the mode, cc the group
    typedef struct packed {
        logic [2:0] aaa;
        logic [2:0] bbb;
        logic [1:0] cc;
    } opcode_f_t;

    // one opcode byte, read raw or by field
    typedef union packed {
        logic [`CPU_DW-1:0] raw;
        opcode_f_t          f;
    } opcode_u;

    // timing states, T1 is the opcode fetch
    typedef enum logic [1:0] {T1, T2, T3, T_JAM} t_state_e;

    // instruction classes by bus sequence
    typedef enum logic [2:0] {
        CL_IMM, CL_ZPG_RD, CL_ZPG_WR, CL_IMPL, CL_JMP, CL_BAD
    } op_class_e;

    typedef enum logic [2:0] {
        ALU_PASS, ALU_ADC, ALU_AND, ALU_ORA, ALU_EOR, ALU_INC, ALU_DEC
    } alu_op_e;

    typedef enum logic [1:0] {R_A, R_X, R_Y, R_NONE} reg_sel_e;

    // decoded instruction
    typedef struct packed {
        op_class_e op_class;
        alu_op_e   alu_op;
        reg_sel_e  src;
        reg_sel_e  dst;
        logic      carry_set;
        logic      carry_clr;
    } dec_t;

    // controls for the edge that ends the current cycle
    typedef struct packed {
        logic sync;
        logic pc_inc;
        logic lo_latch;
        logic addr_zp;
        logic pc_jump;
        logic write;
    } bus_ctl_t;

    // execute strobe, operand from memory or from src
    typedef struct packed {
        logic exec;
        logic from_mem;
    } exec_t;

endpackage

// File: rtl/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data and address bus widths
`define CPU_DW 8
`define CPU_AW 16

// first opcode fetch after reset
`define CPU_RESET_ADDR 16'h0200
// high address byte of every zero-page access
`define CPU_ZP_PAGE 8'h00

// loads, immediate and zero page
`define OPC_LDA_IMM 8'hA9
`define OPC_LDA_ZP  8'hA5
`define OPC_LDX_IMM 8'hA2
`define OPC_LDX_ZP  8'hA6
`define OPC_LDY_IMM 8'hA0
`define OPC_LDY_ZP  8'hA4

// stores, zero page only
`define OPC_STA_ZP  8'h85
`define OPC_STX_ZP  8'h86
`define OPC_STY_ZP  8'h84

// accumulator ALU ops
`define OPC_ADC_IMM 8'h69
`define OPC_ADC_ZP  8'h65
`define OPC_AND_IMM 8'h29
`define OPC_AND_ZP  8'h25
`define OPC_ORA_IMM 8'h09
`define OPC_ORA_ZP  8'h05
`define OPC_EOR_IMM 8'h49
`define OPC_EOR_ZP  8'h45

// implied register ops
`define OPC_INX     8'hE8
`define OPC_INY     8'hC8
`define OPC_DEX     8'hCA
`define OPC_DEY     8'h88
`define OPC_TAX     8'hAA
`define OPC_TAY     8'hA8
`define OPC_TXA     8'h8A
`define OPC_TYA     8'h98
`define OPC_CLC     8'h18
`define OPC_SEC     8'h38
`define OPC_NOP     8'hEA

// absolute jump
`define OPC_JMP_ABS 8'h4C

`endif
